/* all.f */
rtl/qmem_pkg.sv
rtl/qmem_decoder.sv
rtl/qmem_arbiter.sv
rtl/qmem_bus.sv
rtl/qmem_ram.sv
rtl/qmem_rom.sv
rtl/qmem_regs.sv
rtl/qmem_top.sv
tests/qmem_bus_checker.sv
tests/qmem_tb.sv

/* rom.hex */
// one 32-bit word per line, rom word offsets 0 to 15 in order
3c1d_0000
a5a5_5a5a
0000_0013
dead_beef
1234_5678
8765_4321
cafe_f00d
0f0f_f0f0
55aa_aa55
0bad_c0de
7fff_ffff
8000_0001
1357_9bdf
2468_ace0
fedc_ba98
600d_d00d

/* rtl/qmem_arbiter.sv */
// shares one QMEM slave between MN masters
// fixed priority, master 0 highest; no fairness, a busy m0 can starve others
// grant is combinational when idle and locked until ack or err
// losing masters see ack and err low and simply wait
`timescale 1ns/1ps

module qmem_arbiter #(
  parameter int MN = 2
)(
  input  logic                         clk,
  input  logic                         rst,
  input  qmem_pkg::qmem_req_t [MN-1:0] m_req,
  output qmem_pkg::qmem_rsp_t [MN-1:0] m_rsp,
  output qmem_pkg::qmem_req_t          s_req,
  input  qmem_pkg::qmem_rsp_t          s_rsp
);
  import qmem_pkg::*;

  // grant index width
  localparam int GW = (MN > 1) ? $clog2(MN) : 1;

  arb_state_t    state;
  logic [GW-1:0] gnt_q;
  logic [GW-1:0] req_gnt;
  logic          req_vld;
  logic [GW-1:0] gnt;
  logic          gnt_vld;
  logic          done;

  ////////////////////////////////////////////////////////////
  // priority pick among current requests
  ////////////////////////////////////////////////////////////
  // scan downwards so the lowest index wins
  always_comb begin
    req_gnt = '0;
    req_vld = 1'b0;
    for (int i = MN - 1; i >= 0; i--) begin
      if (m_req[i].cs) begin
        req_gnt = GW'(i);
        req_vld = 1'b1;
      end
    end
  end

  // locked grant while busy, fresh pick while idle
  assign gnt     = (state == ARB_BUSY) ? gnt_q : req_gnt;
  assign gnt_vld = (state == ARB_BUSY) | req_vld;
  assign done    = s_rsp.ack | s_rsp.err;

  assign s_req = gnt_vld ? m_req[gnt] : '0;

  // read data is shared, handshake only to the owner
  always_comb begin
    for (int i = 0; i < MN; i++) begin
      m_rsp[i].dat_r = s_rsp.dat_r;
      m_rsp[i].ack   = gnt_vld & (gnt == GW'(i)) & s_rsp.ack;
      m_rsp[i].err   = gnt_vld & (gnt == GW'(i)) & s_rsp.err;
    end
  end

  ////////////////////////////////////////////////////////////
  // lock FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ARB_IDLE;
      gnt_q <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          // hold the grant only if the slave did not finish at once
          if (req_vld & ~done) begin
            state <= ARB_BUSY;
            gnt_q <= req_gnt;
          end
        end
        ARB_BUSY: begin
          if (done) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

/* rtl/qmem_bus.sv */
// QMEM interconnect for two masters and three slaves
// m0 (dcpu) decodes adr[23:22]: 00 ram, 01 rom, 10 regs, 11 unmapped
// m1 (icpu) has no decode and always reaches ram
// ram is shared through a fixed-priority arbiter, m0 first
// rom and regs are private to m0
`timescale 1ns/1ps

module qmem_bus (
  input  logic                clk,
  input  logic                rst,
  // master 0 (dcpu)
  input  qmem_pkg::qmem_req_t m0_req,
  output qmem_pkg::qmem_rsp_t m0_rsp,
  // master 1 (icpu)
  input  qmem_pkg::qmem_req_t m1_req,
  output qmem_pkg::qmem_rsp_t m1_rsp,
  // slave 0 (ram)
  output qmem_pkg::qmem_req_t s0_req,
  input  qmem_pkg::qmem_rsp_t s0_rsp,
  // slave 1 (rom)
  output qmem_pkg::qmem_req_t s1_req,
  input  qmem_pkg::qmem_rsp_t s1_rsp,
  // slave 2 (regs)
  output qmem_pkg::qmem_req_t s2_req,
  input  qmem_pkg::qmem_rsp_t s2_rsp
);
  import qmem_pkg::*;

  // m0 decoder ports, indexed by region code
  qmem_req_t [M0_SN-1:0] m0_s_req;
  qmem_rsp_t [M0_SN-1:0] m0_s_rsp;

  // ram arbiter ports, index is master number
  qmem_req_t [S0_MN-1:0] s0_m_req;
  qmem_rsp_t [S0_MN-1:0] s0_m_rsp;

  ////////////////////////////////////////////////////////////
  // master 0 (dcpu)
  ////////////////////////////////////////////////////////////
  qmem_decoder #(
    .SN    (M0_SN)
  ) m0_decoder_i (
    .clk   (clk),
    .rst   (rst),
    .m_req (m0_req),
    .m_rsp (m0_rsp),
    .s_req (m0_s_req),
    .s_rsp (m0_s_rsp)
  );

  ////////////////////////////////////////////////////////////
  // slave 0 (ram), shared by m0 and m1
  ////////////////////////////////////////////////////////////
  assign s0_m_req[0] = m0_s_req[REGION_RAM];
  assign s0_m_req[1] = m1_req;

  qmem_arbiter #(
    .MN    (S0_MN)
  ) s0_arbiter_i (
    .clk   (clk),
    .rst   (rst),
    .m_req (s0_m_req),
    .m_rsp (s0_m_rsp),
    .s_req (s0_req),
    .s_rsp (s0_rsp)
  );

  assign m0_s_rsp[REGION_RAM] = s0_m_rsp[0];
  // master 1 (icpu) sees only the ram
  assign m1_rsp = s0_m_rsp[1];

  ////////////////////////////////////////////////////////////
  // slaves 1 and 2, m0 only
  ////////////////////////////////////////////////////////////
  // rom
  assign s1_req                = m0_s_req[REGION_ROM];
  assign m0_s_rsp[REGION_ROM]  = s1_rsp;

  // regs
  assign s2_req                = m0_s_req[REGION_REGS];
  assign m0_s_rsp[REGION_REGS] = s2_rsp;

endmodule

/* rtl/qmem_decoder.sv */
// splits one QMEM master onto SN slave ports by address bits 23:22
// region code n goes to port n; codes at or above SN are unmapped
// unmapped access answers err one cycle after cs, once per request
// the master must hold its request until ack or err
`timescale 1ns/1ps

module qmem_decoder #(
  parameter int SN = 3
)(
  input  logic                         clk,
  input  logic                         rst,
  input  qmem_pkg::qmem_req_t          m_req,
  output qmem_pkg::qmem_rsp_t          m_rsp,
  output qmem_pkg::qmem_req_t [SN-1:0] s_req,
  input  qmem_pkg::qmem_rsp_t [SN-1:0] s_rsp
);
  import qmem_pkg::*;

  qmem_region_t  region;
  // one hot slave select
  logic [SN-1:0] ss;
  logic          na;
  logic          na_err;

  ////////////////////////////////////////////////////////////
  // slave select
  ////////////////////////////////////////////////////////////
  assign region = m_req.adr[QAW-1 -: $bits(qmem_region_t)];

  always_comb begin
    for (int i = 0; i < SN; i++) begin
      ss[i] = (region == qmem_region_t'(i));
    end
  end

  // no port matches
  assign na = ~|ss;

  // all fields fan out, cs only to the chosen port
  always_comb begin
    for (int i = 0; i < SN; i++) begin
      s_req[i]    = m_req;
      s_req[i].cs = m_req.cs & ss[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // unmapped error, same registered rule as a slave
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      na_err <= 1'b0;
    end else begin
      na_err <= m_req.cs & na & ~na_err;
    end
  end

  // response return
  always_comb begin
    m_rsp     = '0;
    m_rsp.err = na & na_err;
    for (int i = 0; i < SN; i++) begin
      if (ss[i]) begin
        m_rsp = s_rsp[i];
      end
    end
  end

endmodule

/* rtl/qmem_pkg.sv */
// shared widths, bus types and constants of the QMEM subsystem
// byte addresses with 32-bit words; address bits 23:22 pick the region
// slave tables are small and alias inside their region
package qmem_pkg;

  ////////////////////////////////////////////////////////////
  // widths and vector types
  ////////////////////////////////////////////////////////////
  localparam int QAW = 24;
  localparam int QDW = 32;
  localparam int QSW = QDW / 8;

  typedef logic [QAW-1:0] qmem_adr_t;
  typedef logic [QDW-1:0] qmem_dat_t;
  typedef logic [QSW-1:0] qmem_sel_t;
  typedef logic [1:0]     qmem_region_t;
  // word offset inside one region, address bits 21:2
  typedef logic [QAW-5:0] qmem_woff_t;

  // region codes on address bits 23:22
  localparam qmem_region_t REGION_RAM  = 2'b00;
  localparam qmem_region_t REGION_ROM  = 2'b01;
  localparam qmem_region_t REGION_REGS = 2'b10;
  localparam qmem_region_t REGION_NA   = 2'b11;

  // topology of the reference map
  localparam int M0_SN = 3;
  localparam int S0_MN = 2;

  ////////////////////////////////////////////////////////////
  // slave sizes and register map
  ////////////////////////////////////////////////////////////
  localparam int    RAM_WORDS = 256;
  localparam int    RAM_AW    = $clog2(RAM_WORDS);
  localparam int    ROM_WORDS = 16;
  localparam int    ROM_AW    = $clog2(ROM_WORDS);
  localparam string ROM_FILE  = "rom.hex";

  localparam qmem_woff_t REG_SCRATCH0  = 'd0;
  localparam qmem_woff_t REG_SCRATCH1  = 'd1;
  localparam qmem_woff_t REG_ID        = 'd2;
  localparam qmem_dat_t  REGS_ID_VALUE = 32'h514d_0001;

  // master to slave
  typedef struct packed {
    logic      cs;
    logic      we;
    qmem_sel_t sel;
    qmem_adr_t adr;
    qmem_dat_t dat_w;
  } qmem_req_t;

  // slave to master
  typedef struct packed {
    qmem_dat_t dat_r;
    logic      ack;
    logic      err;
  } qmem_rsp_t;

  // arbiter lock
  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_t;

endpackage

/* rtl/qmem_ram.sv */
// single-port word RAM on QMEM, RAM_WORDS deep
// word index from adr bits 9:2, higher bits alias
// ack one cycle after cs; held cs gives a transfer every other cycle
// never raises err; contents are not cleared by reset
`timescale 1ns/1ps

module qmem_ram (
  input  logic                clk,
  input  logic                rst,
  input  qmem_pkg::qmem_req_t req,
  output qmem_pkg::qmem_rsp_t rsp
);
  import qmem_pkg::*;

  qmem_dat_t         mem [RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic              accept;
  logic              ack_q;
  qmem_dat_t         dat_q;

  assign idx = req.adr[RAM_AW+1:2];
  // ignore cs in the cycle right after an ack
  assign accept = req.cs & ~ack_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // byte lane writes and registered read
  always_ff @(posedge clk) begin
    if (accept) begin
      if (req.we) begin
        for (int b = 0; b < QSW; b++) begin
          if (req.sel[b]) begin
            mem[idx][8*b +: 8] <= req.dat_w[8*b +: 8];
          end
        end
      end
      dat_q <= mem[idx];
    end
  end

  assign rsp.dat_r = dat_q;
  assign rsp.ack   = ack_q;
  assign rsp.err   = 1'b0;

endmodule

/* rtl/qmem_regs.sv */
// small QMEM register block
// word 0 and 1 are scratch, byte writable, cleared on reset
// word 2 is a read-only id; a write there or any offset above 2 gives err
// offset is the word index in adr bits 21:2, no aliasing
`timescale 1ns/1ps

module qmem_regs (
  input  logic                clk,
  input  logic                rst,
  input  qmem_pkg::qmem_req_t req,
  output qmem_pkg::qmem_rsp_t rsp
);
  import qmem_pkg::*;

  qmem_woff_t woff;
  logic       accept;
  logic       bad;
  qmem_dat_t  rd_dat;
  qmem_dat_t  scratch0;
  qmem_dat_t  scratch1;
  logic       ack_q;
  logic       err_q;
  qmem_dat_t  dat_q;

  assign woff   = req.adr[QAW-3:2];
  assign accept = req.cs & ~(ack_q | err_q);
  assign bad    = (woff > REG_ID) | (req.we & (woff == REG_ID));

  // read mux
  always_comb begin
    case (woff)
      REG_SCRATCH0: rd_dat = scratch0;
      REG_SCRATCH1: rd_dat = scratch1;
      REG_ID:       rd_dat = REGS_ID_VALUE;
      default:      rd_dat = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // scratch writes and handshake
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      scratch0 <= '0;
      scratch1 <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      ack_q <= accept & ~bad;
      err_q <= accept & bad;
      if (accept & req.we & ~bad) begin
        for (int b = 0; b < QSW; b++) begin
          if (req.sel[b] && woff == REG_SCRATCH0) begin
            scratch0[8*b +: 8] <= req.dat_w[8*b +: 8];
          end
          if (req.sel[b] && woff == REG_SCRATCH1) begin
            scratch1[8*b +: 8] <= req.dat_w[8*b +: 8];
          end
        end
      end
    end
  end

  // read data, old value on a write
  always_ff @(posedge clk) begin
    if (accept) begin
      dat_q <= rd_dat;
    end
  end

  assign rsp.dat_r = dat_q;
  assign rsp.ack   = ack_q;
  assign rsp.err   = err_q;

endmodule

/* rtl/qmem_rom.sv */
// read-only word table, ROM_WORDS deep, loaded from ROM_FILE
// index from adr bits 5:2 with aliasing; sel is ignored
// a write answers err and leaves the table as it was
`timescale 1ns/1ps

module qmem_rom (
  input  logic                clk,
  input  logic                rst,
  input  qmem_pkg::qmem_req_t req,
  output qmem_pkg::qmem_rsp_t rsp
);
  import qmem_pkg::*;

  qmem_dat_t         mem [ROM_WORDS];
  logic [ROM_AW-1:0] idx;
  logic              accept;
  logic              ack_q;
  logic              err_q;
  qmem_dat_t         dat_q;

  initial begin
    $readmemh(ROM_FILE, mem);
  end

  assign idx    = req.adr[ROM_AW+1:2];
  assign accept = req.cs & ~(ack_q | err_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= accept & ~req.we;
      err_q <= accept & req.we;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dat_q <= mem[idx];
    end
  end

  assign rsp.dat_r = dat_q;
  assign rsp.ack   = ack_q;
  assign rsp.err   = err_q;

endmodule

/* rtl/qmem_top.sv */
// QMEM subsystem top with the interconnect and its three slaves
// only the two master ports leave this level
// rom contents come from ROM_FILE in the run directory
`timescale 1ns/1ps

module qmem_top (
  input  logic                clk,
  input  logic                rst,
  // master 0 (dcpu)
  input  qmem_pkg::qmem_req_t m0_req,
  output qmem_pkg::qmem_rsp_t m0_rsp,
  // master 1 (icpu)
  input  qmem_pkg::qmem_req_t m1_req,
  output qmem_pkg::qmem_rsp_t m1_rsp
);
  import qmem_pkg::*;

  // slave links
  qmem_req_t s0_req;
  qmem_rsp_t s0_rsp;
  qmem_req_t s1_req;
  qmem_rsp_t s1_rsp;
  qmem_req_t s2_req;
  qmem_rsp_t s2_rsp;

  ////////////////////////////////////////////////////////////
  // interconnect
  ////////////////////////////////////////////////////////////
  qmem_bus bus_i (
    .clk    (clk),
    .rst    (rst),
    .m0_req (m0_req),
    .m0_rsp (m0_rsp),
    .m1_req (m1_req),
    .m1_rsp (m1_rsp),
    .s0_req (s0_req),
    .s0_rsp (s0_rsp),
    .s1_req (s1_req),
    .s1_rsp (s1_rsp),
    .s2_req (s2_req),
    .s2_rsp (s2_rsp)
  );

  ////////////////////////////////////////////////////////////
  // slaves
  ////////////////////////////////////////////////////////////
  qmem_ram ram_i (
    .clk (clk),
    .rst (rst),
    .req (s0_req),
    .rsp (s0_rsp)
  );

  qmem_rom rom_i (
    .clk (clk),
    .rst (rst),
    .req (s1_req),
    .rsp (s1_rsp)
  );

  qmem_regs regs_i (
    .clk (clk),
    .rst (rst),
    .req (s2_req),
    .rsp (s2_rsp)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds and runs the QMEM testbench with Verilator from the project root
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module qmem_tb -f all.f -o qmem_sim &&
./obj_dir/qmem_sim ||
{ echo "qmem simulation run did not pass"; exit 1; }

/* tests/qmem_bus_checker.sv */
// handshake assertions on the QMEM interconnect, bound into qmem_bus
// the ram arbiter lock is seen through its state and the ram request
// all properties are off while rst is high
`timescale 1ns/1ps

module qmem_bus_checker (
  input logic                 clk,
  input logic                 rst,
  input qmem_pkg::qmem_rsp_t  m0_rsp,
  input qmem_pkg::qmem_rsp_t  m1_rsp,
  input qmem_pkg::qmem_req_t  s0_req,
  input qmem_pkg::qmem_rsp_t  s0_rsp,
  input qmem_pkg::qmem_rsp_t  s1_rsp,
  input qmem_pkg::qmem_rsp_t  s2_rsp,
  input qmem_pkg::arb_state_t arb_state
);
  import qmem_pkg::*;

  ////////////////////////////////////////////////////////////
  // ack and err exclusive
  ////////////////////////////////////////////////////////////
  m0_excl_a: assert property (@(posedge clk) disable iff (rst) !(m0_rsp.ack && m0_rsp.err))
    else $error("m0 response has ack and err together");
  m1_excl_a: assert property (@(posedge clk) disable iff (rst) !(m1_rsp.ack && m1_rsp.err))
    else $error("m1 response has ack and err together");
  s0_excl_a: assert property (@(posedge clk) disable iff (rst) !(s0_rsp.ack && s0_rsp.err))
    else $error("ram response has ack and err together");
  s1_excl_a: assert property (@(posedge clk) disable iff (rst) !(s1_rsp.ack && s1_rsp.err))
    else $error("rom response has ack and err together");
  s2_excl_a: assert property (@(posedge clk) disable iff (rst) !(s2_rsp.ack && s2_rsp.err))
    else $error("regs response has ack and err together");

  // locked grant keeps the same request on the ram until it answers
  gnt_lock_a: assert property (@(posedge clk) disable iff (rst)
    (arb_state == ARB_BUSY) |-> $stable(s0_req))
    else $error("ram request changed while the arbiter was locked");

  // slave responses are single-cycle pulses
  s0_pulse_a: assert property (@(posedge clk) disable iff (rst)
    (s0_rsp.ack || s0_rsp.err) |=> !(s0_rsp.ack || s0_rsp.err))
    else $error("ram response held longer than one cycle");
  s1_pulse_a: assert property (@(posedge clk) disable iff (rst)
    (s1_rsp.ack || s1_rsp.err) |=> !(s1_rsp.ack || s1_rsp.err))
    else $error("rom response held longer than one cycle");
  s2_pulse_a: assert property (@(posedge clk) disable iff (rst)
    (s2_rsp.ack || s2_rsp.err) |=> !(s2_rsp.ack || s2_rsp.err))
    else $error("regs response held longer than one cycle");

endmodule

bind qmem_bus qmem_bus_checker bus_checker_i (
  .clk       (clk),
  .rst       (rst),
  .m0_rsp    (m0_rsp),
  .m1_rsp    (m1_rsp),
  .s0_req    (s0_req),
  .s0_rsp    (s0_rsp),
  .s1_rsp    (s1_rsp),
  .s2_rsp    (s2_rsp),
  .arb_state (s0_arbiter_i.state)
);

/* tests/qmem_tb.sv */
// directed testbench for qmem_top
// inputs change on posedge by NBA, responses sampled at negedge
// rom.hex must sit in the run directory
// stops at the first error
`timescale 1ns/1ps

module qmem_tb;
  import qmem_pkg::*;

  // cycles a master waits for ack or err
  localparam int TIMEOUT_CYCLES = 20;

  logic      clk;
  logic      rst;
  qmem_req_t m0_req;
  qmem_rsp_t m0_rsp;
  qmem_req_t m1_req;
  qmem_rsp_t m1_rsp;

  // reference contents, ram indexed by word like the slave
  qmem_dat_t ram_model [RAM_WORDS];
  qmem_dat_t rom_model [ROM_WORDS];
  int        seed;

  qmem_top dut_i (
    .clk    (clk),
    .rst    (rst),
    .m0_req (m0_req),
    .m0_rsp (m0_rsp),
    .m1_req (m1_req),
    .m1_rsp (m1_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // new bytes only on the lanes with sel set
  function automatic qmem_dat_t merge_bytes(qmem_dat_t old, qmem_dat_t dat, qmem_sel_t sel);
    qmem_dat_t res;
    res = old;
    for (int b = 0; b < QSW; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = dat[8*b +: 8];
      end
    end
    return res;
  endfunction

  // upper in-region bits alias onto the same word
  function automatic qmem_adr_t ram_adr(logic [RAM_AW-1:0] idx, logic [11:0] hi);
    return {REGION_RAM, hi, idx, 2'b00};
  endfunction

  function automatic qmem_adr_t rom_adr(logic [ROM_AW-1:0] off);
    return {REGION_ROM, 16'h0, off, 2'b00};
  endfunction

  function automatic qmem_adr_t reg_adr(qmem_woff_t woff);
    return {REGION_REGS, woff, 2'b00};
  endfunction

  function automatic qmem_rsp_t outcome(logic ack, logic err);
    qmem_rsp_t rsp;
    rsp       = '0;
    rsp.ack   = ack;
    rsp.err   = err;
    return rsp;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_dat(input string name, input qmem_dat_t exp, input qmem_dat_t act);
    if (exp !== act) begin
      abort_run($sformatf("ERR %s: expected %08h actual %08h", name, exp, act));
    end
  endtask

  // only the handshake outcome, dat_r is checked on its own
  task automatic check_rsp(input string name, input qmem_rsp_t exp, input qmem_rsp_t act);
    if ({exp.ack, exp.err} !== {act.ack, act.err}) begin
      abort_run($sformatf("ERR %s: expected ack=%0b err=%0b actual ack=%0b err=%0b",
                          name, exp.ack, exp.err, act.ack, act.err));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // master transfers, request held until ack or err
  ////////////////////////////////////////////////////////////
  task automatic m0_access(input qmem_adr_t adr, input logic we, input qmem_sel_t sel,
                           input qmem_dat_t dat, output qmem_rsp_t rsp);
    qmem_req_t r;
    int        n;
    r.cs    = 1'b1;
    r.we    = we;
    r.sel   = sel;
    r.adr   = adr;
    r.dat_w = dat;
    n       = 0;
    @(posedge clk);
    m0_req <= r;
    do begin
      @(negedge clk);
      n++;
    end while (!(m0_rsp.ack || m0_rsp.err) && n < TIMEOUT_CYCLES);
    if (!(m0_rsp.ack || m0_rsp.err)) begin
      abort_run($sformatf("m0 got no ack or err within %0d cycles at address %06h",
                          TIMEOUT_CYCLES, adr));
    end else begin
      rsp = m0_rsp;
      // transfer ends with this edge
      @(posedge clk);
      m0_req <= '0;
    end
  endtask

  task automatic m1_access(input qmem_adr_t adr, input logic we, input qmem_sel_t sel,
                           input qmem_dat_t dat, output qmem_rsp_t rsp);
    qmem_req_t r;
    int        n;
    r.cs    = 1'b1;
    r.we    = we;
    r.sel   = sel;
    r.adr   = adr;
    r.dat_w = dat;
    n       = 0;
    @(posedge clk);
    m1_req <= r;
    do begin
      @(negedge clk);
      n++;
    end while (!(m1_rsp.ack || m1_rsp.err) && n < TIMEOUT_CYCLES);
    if (!(m1_rsp.ack || m1_rsp.err)) begin
      abort_run($sformatf("m1 got no ack or err within %0d cycles at address %06h",
                          TIMEOUT_CYCLES, adr));
    end else begin
      rsp = m1_rsp;
      @(posedge clk);
      m1_req <= '0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  // quiet bus, no cs anywhere
  task automatic idle_after_reset();
    repeat (4) begin
      @(negedge clk);
      check_rsp("reset m0", outcome(1'b0, 1'b0), m0_rsp);
      check_rsp("reset m1", outcome(1'b0, 1'b0), m1_rsp);
    end
  endtask

  task automatic ram_write_read();
    qmem_rsp_t         rsp;
    logic [31:0]       r;
    logic [RAM_AW-1:0] idx;
    qmem_dat_t         dat;
    qmem_sel_t         sel;
    for (int i = 0; i < 8; i++) begin
      r   = rand_word();
      idx = r[RAM_AW-1:0];
      dat = rand_word();
      m0_access(ram_adr(idx, r[31:20]), 1'b1, 4'hf, dat, rsp);
      check_rsp("ram full write", outcome(1'b1, 1'b0), rsp);
      ram_model[idx] = dat;
      // partial write through an alias of the same word
      sel = r[11:8];
      dat = rand_word();
      m0_access(ram_adr(idx, r[23:12]), 1'b1, sel, dat, rsp);
      check_rsp("ram byte write", outcome(1'b1, 1'b0), rsp);
      ram_model[idx] = merge_bytes(ram_model[idx], dat, sel);
      m0_access(ram_adr(idx, r[31:20]), 1'b0, 4'hf, '0, rsp);
      check_rsp("ram read", outcome(1'b1, 1'b0), rsp);
      check_dat("ram read", ram_model[idx], rsp.dat_r);
    end
  endtask

  task automatic rom_reads();
    qmem_rsp_t         rsp;
    logic [ROM_AW-1:0] off;
    for (int i = 0; i < ROM_WORDS; i++) begin
      off = ROM_AW'(i);
      m0_access(rom_adr(off), 1'b0, 4'hf, '0, rsp);
      check_rsp("rom read", outcome(1'b1, 1'b0), rsp);
      check_dat("rom read", rom_model[off], rsp.dat_r);
    end
    // write is refused, word stays
    off = 4'd5;
    m0_access(rom_adr(off), 1'b1, 4'hf, ~rom_model[off], rsp);
    check_rsp("rom write", outcome(1'b0, 1'b1), rsp);
    m0_access(rom_adr(off), 1'b0, 4'hf, '0, rsp);
    check_rsp("rom read after write", outcome(1'b1, 1'b0), rsp);
    check_dat("rom read after write", rom_model[off], rsp.dat_r);
  endtask

  task automatic regs_and_unmapped();
    qmem_rsp_t   rsp;
    qmem_dat_t   s0_exp;
    qmem_dat_t   s1_exp;
    qmem_dat_t   dat;
    logic [31:0] r;
    // scratch1 still at its reset value
    m0_access(reg_adr(REG_SCRATCH1), 1'b0, 4'hf, '0, rsp);
    check_rsp("scratch1 reset", outcome(1'b1, 1'b0), rsp);
    check_dat("scratch1 reset", '0, rsp.dat_r);
    s0_exp = rand_word();
    m0_access(reg_adr(REG_SCRATCH0), 1'b1, 4'hf, s0_exp, rsp);
    check_rsp("scratch0 write", outcome(1'b1, 1'b0), rsp);
    s1_exp = rand_word();
    m0_access(reg_adr(REG_SCRATCH1), 1'b1, 4'hf, s1_exp, rsp);
    check_rsp("scratch1 write", outcome(1'b1, 1'b0), rsp);
    dat = rand_word();
    m0_access(reg_adr(REG_SCRATCH1), 1'b1, 4'b1010, dat, rsp);
    check_rsp("scratch1 byte write", outcome(1'b1, 1'b0), rsp);
    s1_exp = merge_bytes(s1_exp, dat, 4'b1010);
    m0_access(reg_adr(REG_SCRATCH0), 1'b0, 4'hf, '0, rsp);
    check_rsp("scratch0 read", outcome(1'b1, 1'b0), rsp);
    check_dat("scratch0 read", s0_exp, rsp.dat_r);
    m0_access(reg_adr(REG_SCRATCH1), 1'b0, 4'hf, '0, rsp);
    check_rsp("scratch1 read", outcome(1'b1, 1'b0), rsp);
    check_dat("scratch1 read", s1_exp, rsp.dat_r);
    // id word
    m0_access(reg_adr(REG_ID), 1'b0, 4'hf, '0, rsp);
    check_rsp("id read", outcome(1'b1, 1'b0), rsp);
    check_dat("id read", REGS_ID_VALUE, rsp.dat_r);
    m0_access(reg_adr(REG_ID), 1'b1, 4'hf, ~REGS_ID_VALUE, rsp);
    check_rsp("id write", outcome(1'b0, 1'b1), rsp);
    m0_access(reg_adr(qmem_woff_t'(3)), 1'b0, 4'hf, '0, rsp);
    check_rsp("regs offset 3 read", outcome(1'b0, 1'b1), rsp);
    m0_access(reg_adr(qmem_woff_t'(3)), 1'b1, 4'hf, '0, rsp);
    check_rsp("regs offset 3 write", outcome(1'b0, 1'b1), rsp);
    // region 11 has no slave
    r = rand_word();
    m0_access({REGION_NA, r[21:0]}, 1'b0, 4'hf, '0, rsp);
    check_rsp("unmapped read", outcome(1'b0, 1'b1), rsp);
    m0_access({REGION_NA, r[31:10]}, 1'b1, 4'hf, r, rsp);
    check_rsp("unmapped write", outcome(1'b0, 1'b1), rsp);
  endtask

  task automatic shared_ram();
    qmem_rsp_t         rsp0;
    qmem_rsp_t         rsp1;
    logic [31:0]       r;
    logic [RAM_AW-1:0] a;
    logic [RAM_AW-1:0] b;
    logic [RAM_AW-1:0] c;
    r = rand_word();
    a = r[RAM_AW-1:0];
    b = a ^ 8'h01;
    c = a ^ 8'h02;
    ram_model[a] = rand_word();
    ram_model[b] = rand_word();
    m0_access(ram_adr(a, 12'h0), 1'b1, 4'hf, ram_model[a], rsp0);
    check_rsp("shared m0 write a", outcome(1'b1, 1'b0), rsp0);
    m0_access(ram_adr(b, 12'h0), 1'b1, 4'hf, ram_model[b], rsp0);
    check_rsp("shared m0 write b", outcome(1'b1, 1'b0), rsp0);
    m1_access(ram_adr(a, r[31:20]), 1'b0, 4'hf, '0, rsp1);
    check_rsp("shared m1 read a", outcome(1'b1, 1'b0), rsp1);
    check_dat("shared m1 read a", ram_model[a], rsp1.dat_r);
    // both masters start on the same edge
    fork
      m0_access(ram_adr(a, 12'h0), 1'b0, 4'hf, '0, rsp0);
      m1_access(ram_adr(b, 12'h0), 1'b0, 4'hf, '0, rsp1);
    join
    check_rsp("contended m0 read", outcome(1'b1, 1'b0), rsp0);
    check_dat("contended m0 read", ram_model[a], rsp0.dat_r);
    check_rsp("contended m1 read", outcome(1'b1, 1'b0), rsp1);
    check_dat("contended m1 read", ram_model[b], rsp1.dat_r);
    ram_model[c] = rand_word();
    m1_access(ram_adr(c, 12'h0), 1'b1, 4'hf, ram_model[c], rsp1);
    check_rsp("shared m1 write", outcome(1'b1, 1'b0), rsp1);
    m0_access(ram_adr(c, 12'h0), 1'b0, 4'hf, '0, rsp0);
    check_rsp("shared m0 read c", outcome(1'b1, 1'b0), rsp0);
    check_dat("shared m0 read c", ram_model[c], rsp0.dat_r);
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed = 32'h82a2_5c53;
    rst    <= 1'b1;
    m0_req <= '0;
    m1_req <= '0;
    $readmemh(ROM_FILE, rom_model);
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    idle_after_reset();
    ram_write_read();
    rom_reads();
    regs_and_unmapped();
    shared_ram();
    $display("Test completed successfully");
    $finish;
  end

endmodule
